// File: common/rename_consts.svh
`ifndef RENAME_CONSTS_SVH
`define RENAME_CONSTS_SVH

// register file sizes of the rename block

`define ARCH_REGS   32          // rv32i integer registers x0..x31
`define PHYS_REGS   64          // physical register file entries

// free list holds every physical register not named by an architectural one
`define FREE_DEPTH  32          // PHYS_REGS - ARCH_REGS

// index widths
`define AREG_W      5           // $clog2(ARCH_REGS)
`define PREG_W      6           // $clog2(PHYS_REGS)

`endif

// File: common/rename_pkg.sv
`default_nettype none

`include "rename_consts.svh"

package rename_pkg;

    // register indices
    typedef logic [`AREG_W-1:0] areg_t;     // architectural index
    typedef logic [`PREG_W-1:0] preg_t;     // physical index

    // one rename request from decode
    typedef struct packed {
        areg_t rd;      // destination
        areg_t rs1;     // first source
        areg_t rs2;     // second source
    } rename_req_t;

    // rename result returned one cycle after acceptance
    typedef struct packed {
        preg_t prd;         // newly allocated destination, 0 for x0
        preg_t old_prd;     // previous speculative mapping of rd
        preg_t prs1;        // physical source 1
        preg_t prs2;        // physical source 2
    } rename_rsp_t;

    // retirement of one instruction
    typedef struct packed {
        areg_t rd;      // architectural destination
        preg_t prd;     // physical register it was renamed to
    } commit_t;

endpackage : rename_pkg

`default_nettype wire

// File: free_list/free_list.sv
`default_nettype none

`include "rename_consts.svh"

module free_list
    import rename_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    // dequeue side, driven by the speculative map
    input  logic  alloc,
    output preg_t alloc_preg,

    // enqueue side, driven by the committed map
    input  logic  release_valid,
    input  preg_t release_preg,

    output logic  free_empty
);

    // pointers carry one extra bit above the address so that full and
    // empty can be told apart when the address bits match
    logic [$clog2(`FREE_DEPTH):0]   head_ptr;   // next entry to hand out
    logic [$clog2(`FREE_DEPTH):0]   tail_ptr;   // next slot to fill

    preg_t                          mem [`FREE_DEPTH];

    logic                           deq;        // qualified dequeue
    logic                           enq;        // qualified enqueue

    // empty when both address and wrap bit agree
    assign free_empty = (head_ptr == tail_ptr);

    // head entry is always visible and taken by the map when it allocates
    assign alloc_preg = mem[head_ptr[$clog2(`FREE_DEPTH)-1:0]];

    assign deq = alloc && !free_empty;      // never pop an empty queue
    assign enq = release_valid;             // conservation keeps room for every release

    // pointer update
    always_ff @(posedge clk) begin
        if (rst) begin
            head_ptr <= '0;
            tail_ptr <= {1'b1, {$clog2(`FREE_DEPTH){1'b0}}};    // wrap bit set so the queue starts full
        end else begin
            if (deq) begin
                head_ptr <= head_ptr + 1'b1;
            end
            if (enq) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
        end
    end

    // storage
    // after reset the list holds 32..63 in ascending order, so the
    // first allocations follow the identity-mapped registers
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `FREE_DEPTH; i++) begin
                mem[i] <= preg_t'(`ARCH_REGS + i);
            end
        end else if (enq) begin
            mem[tail_ptr[$clog2(`FREE_DEPTH)-1:0]] <= release_preg;
        end
    end

endmodule : free_list

`default_nettype wire

// File: rename/rename_map.sv
`default_nettype none

`include "rename_consts.svh"

module rename_map
    import rename_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    // request side
    input  logic        rename_valid,
    input  rename_req_t rename_req,
    output logic        rename_stall,

    // response side
    output logic        rsp_valid,
    output rename_rsp_t rename_rsp,

    // free list
    output logic        alloc,
    input  preg_t       alloc_preg,
    input  logic        free_empty
);

    preg_t       spec_map [`ARCH_REGS];     // speculative architectural to physical map
    logic        accept;                    // request taken this cycle
    logic        rd_nz;                     // destination is not x0
    rename_rsp_t rsp_d;

    assign rd_nz = (rename_req.rd != '0);

    // only a real destination needs a free register
    assign rename_stall = free_empty && rd_nz;
    assign accept       = rename_valid && !rename_stall;
    assign alloc        = accept && rd_nz;

    // lookups read the table before this request's write lands,
    // so rs1 == rd sees the older mapping
    always_comb begin
        rsp_d.prs1    = (rename_req.rs1 == '0) ? '0 : spec_map[rename_req.rs1];
        rsp_d.prs2    = (rename_req.rs2 == '0) ? '0 : spec_map[rename_req.rs2];
        rsp_d.old_prd = rd_nz ? spec_map[rename_req.rd] : '0;
        rsp_d.prd     = rd_nz ? alloc_preg : '0;    // x0 is never renamed
    end

    // map table
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                spec_map[i] <= preg_t'(i);          // identity map
            end
        end else if (alloc) begin
            spec_map[rename_req.rd] <= alloc_preg;
        end
    end

    // response valid
    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= accept;
        end
    end

    // response payload only loaded on acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            rename_rsp <= rsp_d;
        end
    end

endmodule : rename_map

`default_nettype wire

// File: rename/commit_map.sv
`default_nettype none

`include "rename_consts.svh"

module commit_map
    import rename_pkg::*;
(
    input  logic    clk,
    input  logic    rst,

    // retirement strobe
    input  logic    commit_valid,
    input  commit_t commit,

    // superseded register back to the free list
    output logic    release_valid,
    output preg_t   release_preg
);

    preg_t arch_map [`ARCH_REGS];   // committed architectural state

    // the entry being overwritten is no longer reachable once this
    // instruction retires, so it can be recycled right away
    assign release_valid = commit_valid && (commit.rd != '0);
    assign release_preg  = arch_map[commit.rd];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                arch_map[i] <= preg_t'(i);          // same identity as the speculative map
            end
        end else if (release_valid) begin
            arch_map[commit.rd] <= commit.prd;      // x0 entry never written
        end
    end

endmodule : commit_map

`default_nettype wire

// File: hdl/rename_unit.sv
`default_nettype none

module rename_unit
    import rename_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    // rename port
    input  logic        rename_valid,
    input  rename_req_t rename_req,
    output logic        rename_stall,
    output logic        rsp_valid,
    output rename_rsp_t rename_rsp,

    // commit port
    input  logic        commit_valid,
    input  commit_t     commit
);

    logic  alloc;           // map takes the head of the free list
    preg_t alloc_preg;
    logic  free_empty;
    logic  release_valid;   // committed map frees a register
    preg_t release_preg;

    rename_map rename_map_i (
        .clk          (clk),
        .rst          (rst),
        .rename_valid (rename_valid),
        .rename_req   (rename_req),
        .rename_stall (rename_stall),
        .rsp_valid    (rsp_valid),
        .rename_rsp   (rename_rsp),
        .alloc        (alloc),
        .alloc_preg   (alloc_preg),
        .free_empty   (free_empty)
    );

    free_list free_list_i (
        .clk           (clk),
        .rst           (rst),
        .alloc         (alloc),
        .alloc_preg    (alloc_preg),
        .release_valid (release_valid),
        .release_preg  (release_preg),
        .free_empty    (free_empty)
    );

    commit_map commit_map_i (
        .clk           (clk),
        .rst           (rst),
        .commit_valid  (commit_valid),
        .commit        (commit),
        .release_valid (release_valid),
        .release_preg  (release_preg)
    );

endmodule : rename_unit

`default_nettype wire

// File: tb/rename_unit_assertions.sv
`default_nettype none

`include "rename_consts.svh"

module rename_unit_assertions (
    input logic                         clk,
    input logic                         rst,
    input logic                         alloc,
    input logic                         free_empty,
    input logic                         release_valid,
    input logic [$clog2(`FREE_DEPTH):0] head_ptr,
    input logic [$clog2(`FREE_DEPTH):0] tail_ptr,
    input logic                         rename_valid,
    input logic                         rename_stall,
    input logic                         rsp_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int AW = $clog2(`FREE_DEPTH);

    logic queue_full;

    // wrap bits differ while the addresses match
    assign queue_full = (head_ptr[AW] != tail_ptr[AW]) && (head_ptr[AW-1:0] == tail_ptr[AW-1:0]);

    no_release_when_full: assert property (@(posedge clk) disable iff (rst)
        release_valid |-> !queue_full)
        else $error("free list received a release while it was full");

    no_alloc_when_empty: assert property (@(posedge clk) disable iff (rst)
        alloc |-> !free_empty)
        else $error("register allocated from an empty free list");

    no_rsp_after_stall: assert property (@(posedge clk) disable iff (rst)
        (rename_valid && rename_stall) |=> !rsp_valid)
        else $error("response produced for a stalled request");

endmodule : rename_unit_assertions

bind free_list rename_unit_assertions free_list_chk (
    .clk           (clk),
    .rst           (rst),
    .alloc         (alloc),
    .free_empty    (free_empty),
    .release_valid (release_valid),
    .head_ptr      (head_ptr),
    .tail_ptr      (tail_ptr),
    .rename_valid  (1'b0),
    .rename_stall  (1'b0),
    .rsp_valid     (1'b0)
);

bind rename_map rename_unit_assertions rename_map_chk (
    .clk           (clk),
    .rst           (rst),
    .alloc         (alloc),
    .free_empty    (free_empty),
    .release_valid (1'b0),
    .head_ptr      ('0),
    .tail_ptr      ('0),
    .rename_valid  (rename_valid),
    .rename_stall  (rename_stall),
    .rsp_valid     (rsp_valid)
);

`default_nettype wire

// File: tb/rename_unit_tb.sv
`default_nettype none

`include "rename_consts.svh"

module rename_unit_tb
    import rename_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 20;
    localparam int N_RANDOM   = 500;
    localparam int TOTAL_OPS  = N_RANDOM + 200;     // directed tests plus random mix

    logic        clk;
    logic        rst;
    logic        rename_valid;
    rename_req_t rename_req;
    logic        rename_stall;
    logic        rsp_valid;
    rename_rsp_t rename_rsp;
    logic        commit_valid;
    commit_t     commit;

    preg_t       ref_spec [`ARCH_REGS];     // expected speculative map
    preg_t       ref_arch [`ARCH_REGS];     // expected committed map
    preg_t       ref_free [$];              // expected free list with the head first
    rename_rsp_t exp_q [$];
    string       name_q [$];
    commit_t     inflight [$];              // renamed but not committed with the oldest first
    string       test_name;
    int          stall_count;
    int          rsp_count;
    logic        rsp_due;                   // request accepted in the previous cycle
    logic [31:0] lfsr_state;

    rename_unit rename_unit_i (
        .clk          (clk),
        .rst          (rst),
        .rename_valid (rename_valid),
        .rename_req   (rename_req),
        .rename_stall (rename_stall),
        .rsp_valid    (rsp_valid),
        .rename_rsp   (rename_rsp),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // galois lfsr with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) begin
            lfsr_state = lfsr_state ^ 32'h80200003;
        end
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic rename_req_t make_req(input int rd, input int rs1, input int rs2);
        rename_req_t r;
        r.rd  = areg_t'(rd);
        r.rs1 = areg_t'(rs1);
        r.rs2 = areg_t'(rs2);
        return r;
    endfunction

    function automatic void reset_model();
        ref_free.delete();
        for (int i = 0; i < `ARCH_REGS; i++) begin
            ref_spec[i] = preg_t'(i);
            ref_arch[i] = preg_t'(i);
        end
        for (int i = 0; i < `FREE_DEPTH; i++) begin
            ref_free.push_back(preg_t'(`ARCH_REGS + i));
        end
    endfunction

    // predicts the response of an accepted request and queues it
    function automatic rename_rsp_t ref_rename(input rename_req_t req);
        rename_rsp_t r;
        r.prs1    = (req.rs1 == '0) ? '0 : ref_spec[req.rs1];
        r.prs2    = (req.rs2 == '0) ? '0 : ref_spec[req.rs2];
        r.old_prd = '0;
        r.prd     = '0;
        if (req.rd != '0) begin
            r.old_prd        = ref_spec[req.rd];
            r.prd            = ref_free.pop_front();
            ref_spec[req.rd] = r.prd;
        end
        exp_q.push_back(r);
        name_q.push_back(test_name);
        return r;
    endfunction

    function automatic void ref_commit(input commit_t cm);
        if (cm.rd != '0) begin
            ref_free.push_back(ref_arch[cm.rd]);    // superseded register goes to the tail
            ref_arch[cm.rd] = cm.prd;
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("mismatch %s: expected %0d actual %0d", name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "value check failed");
        end
    endtask

    // one clock of stimulus checked at the falling edge
    task automatic drive_cycle(input logic ren, input rename_req_t req, input logic com,
                               input commit_t cm, output logic accepted);
        logic        exp_stall;
        rename_rsp_t rsp;
        commit_t     entry;
        @(posedge clk);
        rename_valid <= ren;
        rename_req   <= req;
        commit_valid <= com;
        commit       <= cm;
        @(negedge clk);
        check_value({test_name, " rsp_valid"}, 32'(rsp_due), 32'(rsp_valid));
        exp_stall = (ref_free.size() == 0) && (req.rd != '0);
        check_value({test_name, " rename_stall"}, 32'(exp_stall), 32'(rename_stall));
        accepted = ren && !exp_stall;
        rsp_due  = accepted;                    // response belongs to the next cycle
        if (ren && exp_stall) begin
            stall_count++;
        end
        if (accepted) begin
            rsp = ref_rename(req);              // sees the free list before this commit
            if (req.rd != '0) begin
                entry.rd  = req.rd;
                entry.prd = rsp.prd;
                inflight.push_back(entry);
            end
        end
        if (com) begin
            ref_commit(cm);
        end
    endtask

    task automatic idle_cycle();
        logic acc;
        drive_cycle(1'b0, '0, 1'b0, '0, acc);
    endtask

    task automatic commit_oldest();
        logic acc;
        drive_cycle(1'b0, '0, 1'b1, inflight.pop_front(), acc);
    endtask

    // holds the request until accepted and forces a commit while it is held
    task automatic issue_rename(input rename_req_t req, input logic random_commit);
        logic    accepted;
        logic    held;
        logic    com;
        commit_t cm;
        held     = 1'b0;
        accepted = 1'b0;
        while (!accepted) begin
            com = 1'b0;
            cm  = '0;
            if (inflight.size() > 0 && (held || (random_commit && lfsr_bit() && lfsr_bit()))) begin
                cm  = inflight.pop_front();
                com = 1'b1;
            end
            drive_cycle(1'b1, req, com, cm, accepted);
            held = !accepted;
        end
    endtask

    initial begin : compare
        rename_rsp_t exp;
        string       nm;
        forever begin
            @(negedge clk);
            if (!rst && rsp_valid) begin
                if (exp_q.size() == 0) begin
                    $display("rsp_valid went high with no accepted request");
                    $display("*** FAILED ***");
                    $fatal(1, "unexpected response");
                end else begin
                    exp = exp_q.pop_front();
                    nm  = name_q.pop_front();
                    check_value({nm, " prd"}, 32'(exp.prd), 32'(rename_rsp.prd));
                    check_value({nm, " old_prd"}, 32'(exp.old_prd), 32'(rename_rsp.old_prd));
                    check_value({nm, " prs1"}, 32'(exp.prs1), 32'(rename_rsp.prs1));
                    check_value({nm, " prs2"}, 32'(exp.prs2), 32'(rename_rsp.prs2));
                    rsp_count++;
                end
            end
        end
    end

    initial begin : watchdog
        #(TOTAL_OPS * 40 * CLK_PERIOD);
        $display("*** FAILED ***");
        $fatal(1, "timeout, the run did not finish within %0d cycles", TOTAL_OPS * 40);
    end

    initial begin : main
        rename_req_t req;
        int          stalls_before;
        logic        acc;
        rst          = 1'b1;
        rename_valid = 1'b0;
        rename_req   = '0;
        commit_valid = 1'b0;
        commit       = '0;
        lfsr_state   = 32'h67bb7319;
        stall_count  = 0;
        rsp_count    = 0;
        rsp_due      = 1'b0;
        test_name    = "reset";
        reset_model();
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        test_name = "reset_identity";
        repeat (3) idle_cycle();
        for (int i = 0; i < `ARCH_REGS; i++) begin
            issue_rename(make_req(0, i, `ARCH_REGS - 1 - i), 1'b0);
        end

        test_name = "alloc_order";
        for (int i = 1; i <= 8; i++) begin
            issue_rename(make_req(i, i - 1, i), 1'b0);     // rs2 == rd reads the older mapping
        end
        issue_rename(make_req(3, 3, 8), 1'b0);
        issue_rename(make_req(9, 3, 3), 1'b0);

        test_name = "x0_dest";
        issue_rename(make_req(0, 0, 5), 1'b0);
        issue_rename(make_req(0, 7, 0), 1'b0);
        drive_cycle(1'b0, '0, 1'b1, '0, acc);               // commit of x0 frees nothing
        issue_rename(make_req(10, 0, 0), 1'b0);

        test_name = "stall_release";
        while (ref_free.size() > 0) begin
            issue_rename(make_req(ref_free.size() % 31 + 1, 1, 2), 1'b0);
        end
        issue_rename(make_req(0, 4, 5), 1'b0);              // x0 passes an empty free list
        stalls_before = stall_count;
        issue_rename(make_req(12, 12, 1), 1'b0);
        check_value("stall_release stall cycles", 32'd2, 32'(stall_count - stalls_before));

        test_name = "commit_recycle";
        while (inflight.size() > 0) begin
            commit_oldest();
        end
        for (int i = 0; i < 24; i++) begin
            issue_rename(make_req(i % 31 + 1, (i * 7) % 32, (i * 3) % 32), 1'b0);
        end

        test_name = "random_mix";
        for (int n = 0; n < N_RANDOM; n++) begin
            if (lfsr_bit()) begin
                req.rd  = areg_t'(rand_bits(`AREG_W));
                req.rs1 = areg_t'(rand_bits(`AREG_W));
                req.rs2 = areg_t'(rand_bits(`AREG_W));
                issue_rename(req, 1'b1);
            end else if (lfsr_bit() && inflight.size() > 0) begin
                commit_oldest();
            end else begin
                idle_cycle();
            end
        end

        test_name = "drain";
        repeat (3) idle_cycle();
        if (exp_q.size() == 0 && rsp_count > 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("%0d expected responses never arrived", exp_q.size());
            $display("*** FAILED ***");
            $fatal(1, "missing responses");
        end
    end

endmodule : rename_unit_tb

`default_nettype wire

// File: rename_unit.f
+incdir+common
common/rename_pkg.sv
free_list/free_list.sv
rename/rename_map.sv
rename/commit_map.sv
hdl/rename_unit.sv
tb/rename_unit_assertions.sv
tb/rename_unit_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 \
    --timescale 1ns/1ps \
    --top-module rename_unit_tb \
    -f rename_unit.f \
    -o rename_unit_sim \
    && ./obj_dir/rename_unit_sim \
    || { echo "rename_unit simulation failed"; exit 1; }
